/* sim/dma_vectors.txt */
# name vrender1 vpos1 vpos2 vpos3 hpos1 hpos2 hpos3 base1 base2 base3 row_base row_offset
#      row_en br_obj br_pal tile_addr exp_tile_data exp_row_scr (all hex)
fill_scr1 00f 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0010 0 0 0 05 581f 0000
fill_scr2 00f 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0010 0 0 0 85 5af9 0000
fill_scr3 00f 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0010 0 0 0 e7 5a6b 0000
row_on    00f 0000 0000 0000 0000 0003 0000 0000 0000 0000 0100 0010 1 0 0 05 581f da7d
row_off   00f 0000 0000 0000 0000 0003 0000 0000 0000 0000 0100 0010 0 0 0 85 5af9 0003
obj_lend  00f 0000 0000 0000 0000 0003 0000 0000 0000 0000 0100 0010 0 1 0 e7 5a6b 0003
obj_row   00f 0000 0000 0000 0000 0003 0000 0000 0000 0000 0100 0010 1 1 0 05 581f da7d
skip_scr1 00f 0004 0000 0000 0040 0003 0000 0000 0000 0000 0100 0010 0 0 0 05 581f 0003
skip_scr3 00f 0000 0000 0008 0000 0003 0040 0000 0000 0000 0100 0010 0 0 0 e7 5a6b 0003
fill_base 00f 0000 0000 0000 0000 0003 0000 0040 0000 0000 0100 0010 0 0 0 05 781f 0003
vpos_mix  007 0000 0008 0018 0000 0003 0000 0000 0000 0000 0100 0010 0 0 0 05 5819 0003
pal_lend  007 0000 0008 0018 0000 0005 0000 0000 0000 0000 0100 0010 0 0 1 05 5819 0005
after_pal 007 0000 0008 0018 0000 0005 0000 0000 0000 0000 0100 0010 0 0 0 85 5af9 0005

/* list.f */
rtl/cps_dma_pkg.sv
rtl/line_start.sv
rtl/line_header.sv
rtl/scroll_fetch.sv
rtl/tile_cache.sv
rtl/cps_dma.sv
sim/tb_cps_dma.sv

/* Bender.yml */
package:
  name: cps_dma

sources:
  - rtl/cps_dma_pkg.sv
  - rtl/line_start.sv
  - rtl/line_header.sv
  - rtl/scroll_fetch.sv
  - rtl/tile_cache.sv
  - rtl/cps_dma.sv
  - target: simulation
    files:
      - sim/tb_cps_dma.sv

/* sim/tb_cps_dma.sv */
// Testbench for the CPS video DMA controller
// Runs the DUT against a video RAM model with random bus stalls and checks
// the cache contents, row scroll and bus lending listed in the vector file

`default_nettype none

module tb_cps_dma;

    localparam int          MAX_VEC        = 32;
    // Two lines of up to ~1100 cycles each with stalls, plus margin
    localparam int          CYCLES_PER_VEC = 5000;
    // A header slot never takes more than 32 counts
    localparam int          HDR_SLOTS      = 32;
    localparam logic [16:0] OBJ_ADDR       = 17'h1f00a;
    localparam logic [16:0] PAL_ADDR       = 17'h0c123;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        HB;
    logic [8:0]  vrender1;
    logic [15:0] vram1_base, hpos1, vpos1;
    logic [15:0] vram2_base, hpos2, vpos2;
    logic [15:0] vram3_base, hpos3, vpos3;
    logic [15:0] vram_row_base;
    logic [15:0] row_offset;
    logic        row_en;
    logic [15:0] row_scr;
    logic [7:0]  tile_addr;
    logic [15:0] tile_data;
    logic        br_obj, bg_obj;
    logic        br_pal, bg_pal;
    logic [16:0] vram_addr;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic        vram_cs;
    logic        br;
    logic        bg;

    // Video RAM model state
    logic [16:0] data_addr;
    logic        data_valid;

    string       vec_name [MAX_VEC];
    logic [15:0] vec_val [MAX_VEC][18];
    int          num_vec;
    int          cycles;
    int          limit;
    int          test_err;
    int          obj_cycles;
    int          passed;
    int          failed;

    cps_dma uut (
        .clk, .rst, .pxl_cen, .HB, .vrender1,
        .vram1_base, .hpos1, .vpos1, .vram2_base, .hpos2, .vpos2,
        .vram3_base, .hpos3, .vpos3, .vram_row_base, .row_offset, .row_en,
        .row_scr, .tile_addr, .tile_data, .br_obj, .bg_obj,
        .vram_obj_addr(OBJ_ADDR), .br_pal, .bg_pal, .vram_pal_addr(PAL_ADDR),
        .vram_addr, .vram_data, .vram_ok, .vram_cs, .br, .bg
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Bus grant follows the request, with random stall cycles
    initial begin
        bg = 1'b0;
        void'($urandom(32'h77aa_e5e6));
        forever begin
            @(posedge clk);
            bg <= br && ($urandom % 8 != 0);
        end
    end

    // Data is valid once the address has been held for a cycle
    assign vram_ok = data_valid && (data_addr === vram_addr);

    always @(posedge clk) begin
        pxl_cen    <= ~pxl_cen;
        vram_data  <= vram_addr[15:0] ^ 16'h5a5a;
        data_addr  <= vram_addr;
        data_valid <= vram_cs;
        cycles     <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // OBJ engine must see its own address while it holds the bus
    always @(posedge clk) begin
        if (bg_obj) begin
            obj_cycles++;
            if (vram_addr !== OBJ_ADDR) begin
                $display("[FAIL] obj address: expected %h actual %h", OBJ_ADDR, vram_addr);
                test_err++;
            end
        end
    end

    task automatic read_vectors();
        int    fd;
        int    code;
        string line;
        fd = $fopen("sim/dma_vectors.txt", "r");
        num_vec = 0;
        if (fd != 0) begin
            while (!$feof(fd) && num_vec < MAX_VEC) begin
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line,
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec_name[num_vec], vec_val[num_vec][0], vec_val[num_vec][1],
                        vec_val[num_vec][2], vec_val[num_vec][3], vec_val[num_vec][4],
                        vec_val[num_vec][5], vec_val[num_vec][6], vec_val[num_vec][7],
                        vec_val[num_vec][8], vec_val[num_vec][9], vec_val[num_vec][10],
                        vec_val[num_vec][11], vec_val[num_vec][12], vec_val[num_vec][13],
                        vec_val[num_vec][14], vec_val[num_vec][15], vec_val[num_vec][16],
                        vec_val[num_vec][17]);
                    if (code == 19)
                        num_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        // A one-cycle gap separates the header from the fill
        while (quiet < 4) begin
            @(posedge clk);
            if (!br)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    task automatic wait_lend();
        int steps;
        steps = 0;
        // Only the header may use the bus before the palette engine gets it
        while (!bg_pal) begin
            @(posedge clk);
            if (br && bg && pxl_cen)
                steps++;
        end
        if (steps > HDR_SLOTS) begin
            $display("Palette line held the bus for %0d steps, so a fill ran", steps);
            test_err++;
        end
        if (vram_addr !== PAL_ADDR) begin
            $display("[FAIL] pal address: expected %h actual %h", PAL_ADDR, vram_addr);
            test_err++;
        end
    endtask

    task automatic run_line(input logic lend);
        @(posedge clk);
        HB <= 1'b1;
        repeat (4) @(posedge clk);
        HB <= 1'b0;
        if (lend)
            wait_lend();
        else
            wait_idle();
    endtask

    task automatic run_test(input int i);
        logic expect_obj;
        test_err   = 0;
        obj_cycles = 0;
        expect_obj = vec_val[i][13][0] && !vec_val[i][14][0];
        @(posedge clk);
        vrender1      <= vec_val[i][0][8:0];
        vpos1         <= vec_val[i][1];
        vpos2         <= vec_val[i][2];
        vpos3         <= vec_val[i][3];
        hpos1         <= vec_val[i][4];
        hpos2         <= vec_val[i][5];
        hpos3         <= vec_val[i][6];
        vram1_base    <= vec_val[i][7];
        vram2_base    <= vec_val[i][8];
        vram3_base    <= vec_val[i][9];
        vram_row_base <= vec_val[i][10];
        row_offset    <= vec_val[i][11];
        row_en        <= vec_val[i][12][0];
        br_obj        <= vec_val[i][13][0];
        br_pal        <= vec_val[i][14][0];
        tile_addr     <= vec_val[i][15][7:0];
        repeat (2) @(posedge clk);
        run_line(vec_val[i][14][0]);
        run_line(vec_val[i][14][0]);
        if (vec_val[i][14][0]) begin
            @(posedge clk);
            br_pal <= 1'b0;
            wait_idle();
        end
        @(posedge clk);
        if (tile_data !== vec_val[i][16]) begin
            $display("[FAIL] %s tile_data: expected %h actual %h",
                     vec_name[i], vec_val[i][16], tile_data);
            test_err++;
        end
        if (row_scr !== vec_val[i][17]) begin
            $display("[FAIL] %s row_scr: expected %h actual %h",
                     vec_name[i], vec_val[i][17], row_scr);
            test_err++;
        end
        if (expect_obj && obj_cycles == 0) begin
            $display("%s: bg_obj never rose although br_obj was set", vec_name[i]);
            test_err++;
        end
        if (!expect_obj && obj_cycles != 0) begin
            $display("%s: bg_obj rose without a granted OBJ request", vec_name[i]);
            test_err++;
        end
        if (test_err == 0) begin
            $display("%s passed", vec_name[i]);
            passed++;
        end else begin
            $display("%s failed with %0d errors", vec_name[i], test_err);
            failed++;
        end
    endtask

    initial begin
        rst = 1'b1;
        pxl_cen = 1'b0;
        HB = 1'b0;
        vrender1 = 9'd0;
        {vram1_base, hpos1, vpos1} = '0;
        {vram2_base, hpos2, vpos2} = '0;
        {vram3_base, hpos3, vpos3} = '0;
        vram_row_base = 16'd0;
        row_offset = 16'd0;
        {row_en, br_obj, br_pal} = 3'b000;
        tile_addr = 8'd0;
        vram_data = 16'd0;
        data_addr = 17'd0;
        data_valid = 1'b0;
        cycles = 0;
        limit = 0;
        passed = 0;
        failed = 0;
        test_err = 0;
        obj_cycles = 0;
        read_vectors();
        if (num_vec == 0) begin
            $display("No test vectors could be read from sim/dma_vectors.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            limit = num_vec * CYCLES_PER_VEC;
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            @(posedge clk);
            if ({br, vram_cs, bg_obj, bg_pal} !== 4'b0000) begin
                $display("[FAIL] reset_state: expected 0000 actual %b",
                         {br, vram_cs, bg_obj, bg_pal});
                failed++;
            end else begin
                $display("reset_state passed");
                passed++;
            end
            for (int i = 0; i < num_vec; i++)
                run_test(i);
            $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
            if (failed == 0)
                $display("RESULT: PASS");
            else
                $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/cps_dma.sv */
// CPS video DMA controller
// Chains line start, header, scroll fetch and tile cache, shares the video
// RAM bus among the stages and lends it to the palette engine when idle

`default_nettype none

module cps_dma (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     HB,
    input  cps_dma_pkg::line_t       vrender1,
    input  cps_dma_pkg::scroll_t     vram1_base,
    input  cps_dma_pkg::scroll_t     hpos1,
    input  cps_dma_pkg::scroll_t     vpos1,
    input  cps_dma_pkg::scroll_t     vram2_base,
    input  cps_dma_pkg::scroll_t     hpos2,
    input  cps_dma_pkg::scroll_t     vpos2,
    input  cps_dma_pkg::scroll_t     vram3_base,
    input  cps_dma_pkg::scroll_t     hpos3,
    input  cps_dma_pkg::scroll_t     vpos3,
    input  cps_dma_pkg::scroll_t     vram_row_base,
    input  cps_dma_pkg::scroll_t     row_offset,
    input  logic                     row_en,
    output cps_dma_pkg::scroll_t     row_scr,
    input  cps_dma_pkg::cache_addr_t tile_addr,
    output cps_dma_pkg::vram_word_t  tile_data,
    input  logic                     br_obj,
    output logic                     bg_obj,
    input  cps_dma_pkg::vram_addr_t  vram_obj_addr,
    input  logic                     br_pal,
    output logic                     bg_pal,
    input  cps_dma_pkg::vram_addr_t  vram_pal_addr,
    output cps_dma_pkg::vram_addr_t  vram_addr,
    input  cps_dma_pkg::vram_word_t  vram_data,
    input  logic                     vram_ok,
    output logic                     vram_cs,
    output logic                     br,
    input  logic                     bg
);

    logic                     line_go;
    cps_dma_pkg::line_t       vrender;
    cps_dma_pkg::scroll_t     vscr1;
    cps_dma_pkg::scroll_t     vscr2;
    cps_dma_pkg::scroll_t     vscr3;
    logic                     hdr_busy;
    logic                     hdr_done;
    cps_dma_pkg::vram_addr_t  hdr_addr;
    logic [2:0]               fill_req;
    logic                     fetch_busy;
    logic                     cache_wr;
    cps_dma_pkg::vram_addr_t  fetch_addr;
    cps_dma_pkg::cache_addr_t cache_wa;
    cps_dma_pkg::vram_word_t  cache_wd;
    logic [2:0]               swap_set;
    logic                     pal_own;

    line_start u_line_start (
        .clk, .rst, .HB, .vrender1, .vpos1, .vpos2, .vpos3,
        .line_go, .vrender, .vscr1, .vscr2, .vscr3
    );

    line_header u_line_header (
        .clk, .rst, .pxl_cen, .bg, .line_go, .row_en, .br_obj, .br_pal,
        .vrender, .hpos2, .vram_row_base, .row_offset, .vram_data,
        .vram_obj_addr, .hdr_busy, .bg_obj, .hdr_done, .hdr_addr,
        .fill_req, .row_scr
    );

    scroll_fetch u_scroll_fetch (
        .clk, .rst, .pxl_cen, .bg, .hdr_done, .vram_ok, .fill_req,
        .vscr1, .vscr2, .vscr3, .hpos1, .hpos2, .hpos3,
        .vram1_base, .vram2_base, .vram3_base, .vram_data,
        .fetch_busy, .cache_wr, .fetch_addr, .cache_wa, .cache_wd, .swap_set
    );

    tile_cache u_tile_cache (
        .clk, .rst, .line_go, .cache_wr, .swap_set, .cache_wa,
        .tile_addr, .cache_wd, .tile_data
    );

    // Header and fill own the bus first, palette only when both are idle
    assign br      = hdr_busy | fetch_busy | pal_own;
    assign vram_cs = br;

    always_comb begin
        if (hdr_busy)
            vram_addr = hdr_addr;
        else if (fetch_busy)
            vram_addr = fetch_addr;
        else
            vram_addr = vram_pal_addr;
    end

    // Line start takes the bus back from the palette engine
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pal_own <= 1'b0;
            bg_pal  <= 1'b0;
        end else begin
            pal_own <= br_pal & ~line_go & ~hdr_busy & ~fetch_busy;
            bg_pal  <= pal_own & bg;
        end
    end

endmodule

`default_nettype wire

/* rtl/tile_cache.sv */
// Double-banked tile cache
// One bank per layer is read by the renderer while the other is filled,
// filled layers change banks at the next line start

`default_nettype none

module tile_cache (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     line_go,
    input  logic                     cache_wr,
    input  logic [2:0]               swap_set,
    input  cps_dma_pkg::cache_addr_t cache_wa,
    input  cps_dma_pkg::cache_addr_t tile_addr,
    input  cps_dma_pkg::vram_word_t  cache_wd,
    output cps_dma_pkg::vram_word_t  tile_data
);

    cps_dma_pkg::vram_word_t mem [512];
    logic [2:0]              active;
    logic [2:0]              swap;
    logic                    wr_bank;
    logic                    rd_bank;

    // Bank flag of the layer that owns an index
    function automatic logic bank_flag(input cps_dma_pkg::cache_addr_t a,
                                       input logic [2:0] f);
        cps_dma_pkg::layer_t owner;
        if (!a[7])
            owner = cps_dma_pkg::LAYER_SCR1;
        else if (a <= cps_dma_pkg::SCR2_LAST)
            owner = cps_dma_pkg::LAYER_SCR2;
        else
            owner = cps_dma_pkg::LAYER_SCR3;
        case (owner)
            cps_dma_pkg::LAYER_SCR1: return f[0];
            cps_dma_pkg::LAYER_SCR2: return f[1];
            default:                 return f[2];
        endcase
    endfunction

    assign wr_bank = ~bank_flag(cache_wa, active);
    assign rd_bank = bank_flag(tile_addr, active);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active <= 3'b000;
            swap   <= 3'b000;
        end else if (line_go) begin
            active <= active ^ swap;
            swap   <= swap_set;
        end else begin
            swap <= swap | swap_set;
        end
    end

    always_ff @(posedge clk) begin
        if (cache_wr)
            mem[{wr_bank, cache_wa}] <= cache_wd;
        tile_data <= mem[{rd_bank, tile_addr}];
    end

endmodule

`default_nettype wire

/* rtl/scroll_fetch.sv */
// Scroll tile fetch
// Walks the requested scroll layers in order, reads two tilemap words per
// tile from video RAM and writes them into the inactive cache bank

`default_nettype none

module scroll_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     bg,
    input  logic                     hdr_done,
    input  logic                     vram_ok,
    input  logic [2:0]               fill_req,
    input  cps_dma_pkg::scroll_t     vscr1,
    input  cps_dma_pkg::scroll_t     vscr2,
    input  cps_dma_pkg::scroll_t     vscr3,
    input  cps_dma_pkg::scroll_t     hpos1,
    input  cps_dma_pkg::scroll_t     hpos2,
    input  cps_dma_pkg::scroll_t     hpos3,
    input  cps_dma_pkg::scroll_t     vram1_base,
    input  cps_dma_pkg::scroll_t     vram2_base,
    input  cps_dma_pkg::scroll_t     vram3_base,
    input  cps_dma_pkg::vram_word_t  vram_data,
    output logic                     fetch_busy,
    output logic                     cache_wr,
    output cps_dma_pkg::vram_addr_t  fetch_addr,
    output cps_dma_pkg::cache_addr_t cache_wa,
    output cps_dma_pkg::vram_word_t  cache_wd,
    output logic [2:0]               swap_set
);

    cps_dma_pkg::layer_t      state;
    logic [2:0]               pending;
    logic [2:0]               mask;
    logic                     phase;
    cps_dma_pkg::cache_addr_t idx;
    cps_dma_pkg::cache_addr_t last;
    cps_dma_pkg::scroll_t     base;
    logic [10:0]              vn;
    logic [10:0]              hn;
    logic [10:0]              hstep;
    logic [11:0]              scan;
    cps_dma_pkg::vram_addr_t  word_addr;

    assign fetch_busy = (state != cps_dma_pkg::LAYER_NONE) | (|pending);

    // Tilemap scan order depends on the tile size of the layer
    always_comb begin
        case (state)
            cps_dma_pkg::LAYER_SCR1: begin
                scan  = {vn[8], hn[8:3], vn[7:3]};
                hstep = 11'd8;
            end
            cps_dma_pkg::LAYER_SCR2: begin
                scan  = {vn[9:8], hn[9:4], vn[7:4]};
                hstep = 11'd16;
            end
            default: begin
                scan  = {vn[10:8], hn[10:5], vn[7:5]};
                hstep = 11'd32;
            end
        endcase
    end

    // Even index is the first word of a tile, odd the second
    assign word_addr = {base[9:1], 8'd0} + {4'd0, scan, idx[0]};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= cps_dma_pkg::LAYER_NONE;
            pending  <= 3'b000;
            phase    <= 1'b0;
            cache_wr <= 1'b0;
            swap_set <= 3'b000;
        end else begin
            cache_wr <= 1'b0;
            swap_set <= 3'b000;
            if (hdr_done)
                pending <= fill_req;
            if (state == cps_dma_pkg::LAYER_NONE) begin
                phase <= 1'b0;
                // Unaligned layers are dropped and keep last line's bank
                if (pending[0]) begin
                    pending[0] <= 1'b0;
                    if (vscr1[2:0] == 3'd0)
                        state <= cps_dma_pkg::LAYER_SCR1;
                end else if (pending[1]) begin
                    pending[1] <= 1'b0;
                    if (vscr2[3:0] == 4'd0)
                        state <= cps_dma_pkg::LAYER_SCR2;
                end else if (pending[2]) begin
                    pending[2] <= 1'b0;
                    if (vscr3[3:0] == 4'd0)
                        state <= cps_dma_pkg::LAYER_SCR3;
                end
            end else if (bg) begin
                if (!phase) begin
                    if (pxl_cen)
                        phase <= 1'b1;
                end else if (vram_ok) begin
                    cache_wr <= 1'b1;
                    phase    <= 1'b0;
                    if (idx == last) begin
                        swap_set <= mask;
                        state    <= cps_dma_pkg::LAYER_NONE;
                    end
                end
            end
        end
    end

    // Layer setup and word datapath
    always_ff @(posedge clk) begin
        if (state == cps_dma_pkg::LAYER_NONE) begin
            if (pending[0]) begin
                mask <= 3'b001;
                vn   <= vscr1[10:0];
                hn   <= cps_dma_pkg::SCR1_HOFS + {hpos1[10:3], 3'd0};
                idx  <= cps_dma_pkg::SCR1_FIRST;
                last <= cps_dma_pkg::SCR1_LAST;
                base <= vram1_base;
            end else if (pending[1]) begin
                mask <= 3'b010;
                vn   <= vscr2[10:0];
                hn   <= cps_dma_pkg::SCR2_HOFS + {hpos2[10:4], 4'd0};
                idx  <= cps_dma_pkg::SCR2_FIRST;
                last <= cps_dma_pkg::SCR2_LAST;
                base <= vram2_base;
            end else begin
                mask <= 3'b100;
                vn   <= vscr3[10:0];
                hn   <= cps_dma_pkg::SCR3_HOFS + {hpos3[10:5], 5'd0};
                idx  <= cps_dma_pkg::SCR3_FIRST;
                last <= cps_dma_pkg::SCR3_LAST;
                base <= vram3_base;
            end
        end else if (bg) begin
            if (!phase) begin
                if (pxl_cen)
                    fetch_addr <= word_addr;
            end else if (vram_ok) begin
                cache_wa <= idx;
                cache_wd <= vram_data;
                idx      <= idx + 8'd1;
                // Next column once both words of the tile are in
                if (idx[0])
                    hn <= hn + hstep;
            end
        end
    end

    a_wa_in_range: assert property (@(posedge clk) disable iff (rst)
        cache_wr |->
            (mask == 3'b001 && cache_wa <= cps_dma_pkg::SCR1_LAST) ||
            (mask == 3'b010 && cache_wa inside
                {[cps_dma_pkg::SCR2_FIRST:cps_dma_pkg::SCR2_LAST]}) ||
            (mask == 3'b100 && cache_wa >= cps_dma_pkg::SCR3_FIRST));

endmodule

`default_nettype wire

/* rtl/line_header.sv */
// Line header stage
// Runs the header slot of each line, reads the row-scroll word from the
// row table and lends the bus to the OBJ engine inside the slot

`default_nettype none

module line_header (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    bg,
    input  logic                    line_go,
    input  logic                    row_en,
    input  logic                    br_obj,
    input  logic                    br_pal,
    input  cps_dma_pkg::line_t      vrender,
    input  cps_dma_pkg::scroll_t    hpos2,
    input  cps_dma_pkg::scroll_t    vram_row_base,
    input  cps_dma_pkg::scroll_t    row_offset,
    input  cps_dma_pkg::vram_word_t vram_data,
    input  cps_dma_pkg::vram_addr_t vram_obj_addr,
    output logic                    hdr_busy,
    output logic                    bg_obj,
    output logic                    hdr_done,
    output cps_dma_pkg::vram_addr_t hdr_addr,
    output logic [2:0]              fill_req,
    output cps_dma_pkg::scroll_t    row_scr
);

    logic [4:0]              cnt;
    logic                    step;
    logic                    slot_end;
    cps_dma_pkg::vram_addr_t row_addr;
    cps_dma_pkg::scroll_t    row_next;
    cps_dma_pkg::scroll_t    nibble;

    assign step     = hdr_busy & bg & pxl_cen;
    assign slot_end = (cnt == cps_dma_pkg::HDR_LAST) ||
                      (br_pal && cnt == cps_dma_pkg::HDR_PAL_CUT);
    assign nibble   = {12'd0, hpos2[3:0]};

    // Row table entry for the line being prepared
    assign row_addr = {vram_row_base[9:1], 8'd0}
                    + {7'd0, row_offset[9:0]}
                    + {8'd0, vrender};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hdr_busy <= 1'b0;
            bg_obj   <= 1'b0;
            hdr_done <= 1'b0;
            fill_req <= 3'b000;
            cnt      <= 5'd0;
        end else begin
            hdr_done <= 1'b0;
            if (line_go) begin
                hdr_busy <= 1'b1;
                fill_req <= 3'b000;
                if (row_en)
                    cnt <= 5'd0;
                else if (br_obj)
                    cnt <= cps_dma_pkg::OBJ_START;
                else
                    cnt <= cps_dma_pkg::OBJ_END + 5'd1;
            end else if (step) begin
                cnt <= cnt + 5'd1;
                if (cnt == cps_dma_pkg::OBJ_START) begin
                    bg_obj <= br_obj & ~br_pal;
                    // Row reads done, go straight past the OBJ window
                    if (!br_obj)
                        cnt <= cps_dma_pkg::OBJ_END + 5'd1;
                end
                if (cnt == cps_dma_pkg::OBJ_END)
                    bg_obj <= 1'b0;
                if (slot_end) begin
                    hdr_busy <= 1'b0;
                    bg_obj   <= 1'b0;
                    hdr_done <= 1'b1;
                    fill_req <= br_pal ? 3'b000 : 3'b111;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_go) begin
            row_scr  <= row_next;
            row_next <= nibble;
        end else if (step) begin
            if (cnt >= cps_dma_pkg::OBJ_START)
                hdr_addr <= vram_obj_addr;
            else
                hdr_addr <= row_addr;
            // Row word has had the whole row phase to arrive
            if (cnt == cps_dma_pkg::OBJ_START && row_en)
                row_next <= nibble + vram_data;
        end
    end

    a_obj_in_slot: assert property (@(posedge clk) disable iff (rst)
        bg_obj |-> hdr_busy);

endmodule

`default_nettype wire

/* rtl/line_start.sv */
// Line start stage
// Finds the rising edge of HB, latches the next render line and forms
// the vertical scroll sums used by the fetch for that line

`default_nettype none

module line_start (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 HB,
    input  cps_dma_pkg::line_t   vrender1,
    input  cps_dma_pkg::scroll_t vpos1,
    input  cps_dma_pkg::scroll_t vpos2,
    input  cps_dma_pkg::scroll_t vpos3,
    output logic                 line_go,
    output cps_dma_pkg::line_t   vrender,
    output cps_dma_pkg::scroll_t vscr1,
    output cps_dma_pkg::scroll_t vscr2,
    output cps_dma_pkg::scroll_t vscr3
);

    logic                 last_hb;
    logic                 hb_edge;
    cps_dma_pkg::line_t   next_line;
    cps_dma_pkg::scroll_t next_wide;

    assign hb_edge   = HB & ~last_hb;
    // vrender1 runs one line ahead of the screen, fetch for the one after
    assign next_line = vrender1 + 9'd1;
    assign next_wide = {7'd0, next_line};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_hb <= 1'b0;
            line_go <= 1'b0;
        end else begin
            last_hb <= HB;
            line_go <= hb_edge;
        end
    end

    // Sums settle together with line_go and hold for the whole line
    always_ff @(posedge clk) begin
        if (hb_edge) begin
            vrender <= next_line;
            vscr1   <= vpos1 + next_wide;
            vscr2   <= vpos2 + next_wide;
            vscr3   <= vpos3 + next_wide;
        end
    end

    a_single_go: assert property (@(posedge clk) disable iff (rst)
        line_go |=> !line_go);

endmodule

`default_nettype wire

/* rtl/cps_dma_pkg.sv */
// CPS video DMA shared definitions
// Bus, scroll and cache types, the layer enum and the header and fill constants

`default_nettype none

package cps_dma_pkg;

    typedef logic [16:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;
    typedef logic [15:0] scroll_t;
    typedef logic [8:0]  line_t;
    typedef logic [7:0]  cache_addr_t;

    // Fill state, also names the owner of a cache index
    typedef enum logic [1:0] {
        LAYER_NONE,
        LAYER_SCR1,
        LAYER_SCR2,
        LAYER_SCR3
    } layer_t;

    // Header slot counts
    localparam logic [4:0] OBJ_START   = 5'd7;
    localparam logic [4:0] OBJ_END     = 5'd22;
    localparam logic [4:0] HDR_LAST    = 5'd31;
    localparam logic [4:0] HDR_PAL_CUT = 5'd13;

    // Cache index ranges per layer
    localparam cache_addr_t SCR1_FIRST = 8'd0;
    localparam cache_addr_t SCR1_LAST  = 8'd99;
    localparam cache_addr_t SCR2_FIRST = 8'd128;
    localparam cache_addr_t SCR2_LAST  = 8'd225;
    localparam cache_addr_t SCR3_FIRST = 8'd226;
    localparam cache_addr_t SCR3_LAST  = 8'd255;

    // Horizontal start offsets
    localparam logic [10:0] SCR1_HOFS = 11'h38;
    localparam logic [10:0] SCR2_HOFS = 11'h30;
    localparam logic [10:0] SCR3_HOFS = 11'h20;

endpackage

`default_nettype wire
